/* Bender.yml */
package:
  name: mem_system

sources:
  - files:
      - design/cache_pkg.sv
      - design/cache_port_if.sv
      - design/mem_port_if.sv
      - design/cache_ctrl.sv
      - design/cache_array.sv
      - design/banked_memory.sv
      - design/mem_system.sv
  - target: test
    files:
      - bench/mem_system_tb.sv

/* bench/mem_system_tb.sv */
`timescale 1ns/1ps

module mem_system_tb import cache_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int NUM_DIRECTED = 11;
    localparam int NUM_RANDOM   = 300;
    // Dirty miss with write-back, drain, refill and handshake
    localparam int MISS_CYCLES  = 8 + 2*WORDS_PER_LINE + BANK_OCCUPANCY + MEM_LATENCY;
    localparam longint WATCHDOG_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * MISS_CYCLES + 100;

    logic  clk;
    logic  reset;
    addr_t addr;
    word_t write_data;
    logic  rd;
    logic  wr;
    word_t read_data;
    logic  done;
    logic  stall;
    logic  cache_hit;

    string test_name;
    logic  exp_hit;     // Predicted from the shadow tags
    logic  check_read;
    word_t exp_data;
    logic  sampled_req;

    word_t shadow_mem [addr_t];  // Keyed by word address
    tag_t  shadow_tag [NUM_LINES];
    logic  shadow_valid [NUM_LINES];

    mem_system mem_system_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
        return {t, i, o};
    endfunction

    function automatic word_t stored_word(input addr_t a);
        addr_t key;
        key = {a[15:1], 1'b0};
        if (shadow_mem.exists(key)) begin
            return shadow_mem[key];
        end
        return '0;  // Memory starts cleared
    endfunction

    task automatic issue_request(input string name, input logic is_write, input addr_t a,
                                 input word_t d);
        index_t idx;
        idx = a[10:3];
        @(negedge clk);
        test_name  = name;
        exp_hit    = shadow_valid[idx] && (shadow_tag[idx] == a[15:11]);
        exp_data   = stored_word(a);
        check_read = !is_write;
        addr       = a;
        write_data = d;
        rd         = !is_write;
        wr         = is_write;
        do begin
            @(negedge clk);
        end while (!done);
        rd = 1'b0;
        wr = 1'b0;
        shadow_valid[idx] = 1'b1;  // Every access leaves the line resident
        shadow_tag[idx]   = a[15:11];
        if (is_write) begin
            shadow_mem[{a[15:1], 1'b0}] = d;
        end
    endtask

    assign sampled_req = (rd || wr) && !stall && !done;

    read_value: assert property (@(posedge clk) disable iff (reset)
        done && check_read |-> read_data == exp_data)
        else stop_with_failure($sformatf("Mismatch in %s: expected read_data %h, actual %h",
                                         test_name, exp_data, $sampled(read_data)));

    hit_flag: assert property (@(posedge clk) disable iff (reset)
        done |-> cache_hit == exp_hit)
        else stop_with_failure($sformatf("Mismatch in %s: expected cache_hit %b, actual %b",
                                         test_name, exp_hit, $sampled(cache_hit)));

    hit_latency: assert property (@(posedge clk) disable iff (reset)
        sampled_req && exp_hit |-> ##2 done)
        else stop_with_failure({"Hit did not finish two cycles after sampling in ", test_name});

    stall_start: assert property (@(posedge clk) disable iff (reset)
        sampled_req |=> stall)
        else stop_with_failure({"Stall did not rise after a sampled request in ", test_name});

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        stall |=> stall || done)
        else stop_with_failure({"Stall dropped before done in ", test_name});

    done_no_stall: assert property (@(posedge clk) disable iff (reset)
        done |-> !stall)
        else stop_with_failure({"Stall was high during done in ", test_name});

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else stop_with_failure({"Done lasted longer than one cycle in ", test_name});

    // Request is released in the done cycle, so look one edge back
    done_pending: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(rd || wr) && $past(stall))
        else stop_with_failure({"Done came without a pending request in ", test_name});

    initial begin
        addr_t a;
        void'($urandom(32'h426c_55ae));
        reset      = 1'b1;
        addr       = '0;
        write_data = '0;
        rd         = 1'b0;
        wr         = 1'b0;
        test_name  = "reset";
        exp_hit    = 1'b0;
        exp_data   = '0;
        check_read = 1'b0;
        for (int i = 0; i < NUM_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (!done && !stall && !cache_hit)
            else stop_with_failure("Done, stall or cache_hit high after reset");

        issue_request("reset_read", 1'b0, make_addr(5'd1, 8'h10, 3'd0), '0);
        for (int off = 2; off < 8; off += 2) begin
            issue_request("fill_hit", 1'b0, make_addr(5'd1, 8'h10, offset_t'(off)), '0);
        end

        // Write hit and then write miss with allocate
        issue_request("write_hit", 1'b1, make_addr(5'd1, 8'h10, 3'd4), 16'hbeef);
        issue_request("write_hit", 1'b0, make_addr(5'd1, 8'h10, 3'd4), '0);
        issue_request("write_miss", 1'b1, make_addr(5'd3, 8'h20, 3'd6), 16'h5a5a);
        issue_request("write_miss", 1'b0, make_addr(5'd3, 8'h20, 3'd6), '0);

        // Same index with another tag forces the dirty line out
        issue_request("dirty_evict", 1'b1, make_addr(5'd2, 8'h30, 3'd2), 16'hc0de);
        issue_request("dirty_evict", 1'b0, make_addr(5'd6, 8'h30, 3'd2), '0);
        issue_request("dirty_evict", 1'b0, make_addr(5'd2, 8'h30, 3'd2), '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            a = make_addr(tag_t'($urandom_range(3, 0)), index_t'($urandom_range(3, 0)),
                          offset_t'(2 * $urandom_range(3, 0)));
            issue_request("random_mix", 1'($urandom_range(1, 0)), a, word_t'($urandom));
        end

        repeat (4) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog expired before all requests completed");
    end

endmodule

/* design/banked_memory.sv */
`timescale 1ns/1ps

module banked_memory import cache_pkg::*; (
    input logic clk,
    input logic reset,
    mem_port_if.memory mem
);

    typedef logic [$clog2(BANK_OCCUPANCY+1)-1:0] occ_t;

    // One word of each line per bank
    word_t bank_mem [WORDS_PER_LINE][2**($bits(addr_t)-$bits(offset_t))];

    bank_t                                   bank;
    logic [$bits(addr_t)-$bits(offset_t)-1:0] row;
    occ_t                                    occ_cnt [WORDS_PER_LINE];
    logic                                    accept;
    logic [MEM_LATENCY-1:0]                  pipe_valid;
    word_t                                   pipe_data [MEM_LATENCY];

    assign bank   = mem.addr[2:1];
    assign row    = mem.addr[$bits(addr_t)-1:$bits(offset_t)];
    assign accept = (mem.rd || mem.wr) && !mem.busy;

    assign mem.busy       = (occ_cnt[bank] != '0);
    assign mem.read_valid = pipe_valid[MEM_LATENCY-1];
    assign mem.read_data  = pipe_data[MEM_LATENCY-1];

    always_comb begin
        mem.stall = 1'b0;
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            mem.stall = mem.stall || (occ_cnt[b] != '0);
        end
    end

    // Memory comes up cleared
    initial begin
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            for (int r = 0; r < 2**$bits(row); r++) begin
                bank_mem[b][r] = '0;
            end
        end
    end

    // Bank occupancy and read pipeline valids
    always_ff @(posedge clk) begin
        if (reset) begin
            pipe_valid <= '0;
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                occ_cnt[b] <= '0;
            end
        end else begin
            pipe_valid[0] <= accept && mem.rd;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                if (accept && bank == bank_t'(b)) begin
                    occ_cnt[b] <= occ_t'(BANK_OCCUPANCY);
                end else if (occ_cnt[b] != '0) begin
                    occ_cnt[b] <= occ_cnt[b] - 1'b1;
                end
            end
        end
    end

    // Storage and read data in flight
    always_ff @(posedge clk) begin
        if (accept && mem.wr) begin
            bank_mem[bank][row] <= mem.write_data;
        end
        pipe_data[0] <= bank_mem[bank][row];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

endmodule

/* design/cache_array.sv */
`timescale 1ns/1ps

module cache_array import cache_pkg::*; (
    input logic clk,
    input logic reset,
    cache_port_if.array cache
);

    tag_t                 tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;
    word_t                data_mem [NUM_LINES*WORDS_PER_LINE];

    logic [$clog2(NUM_LINES*WORDS_PER_LINE)-1:0] word_sel;

    logic fill_write;  // Line fill from memory
    logic hit_write;   // Processor write on a hit

    // Index and word offset pick one word
    assign word_sel = {cache.index, cache.offset[2:1]};

    // Combinational lookup
    assign cache.tag_out   = tag_mem[cache.index];
    assign cache.valid     = valid_bits[cache.index];
    assign cache.dirty     = dirty_bits[cache.index];
    assign cache.read_data = data_mem[word_sel];
    assign cache.hit       = cache.enable && cache.compare && cache.valid &&
                             (cache.tag_out == cache.tag);

    assign fill_write = cache.enable && cache.write && !cache.compare;
    assign hit_write  = cache.enable && cache.write && cache.compare && cache.hit;

    // Tags and data
    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_mem[cache.index] <= cache.tag;
        end
        if (fill_write || hit_write) begin
            data_mem[word_sel] <= cache.write_data;
        end
    end

    // Line state bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (fill_write) begin
                valid_bits[cache.index] <= cache.valid_in;
                dirty_bits[cache.index] <= 1'b0;  // Fresh from memory
            end else if (hit_write) begin
                dirty_bits[cache.index] <= 1'b1;
            end
        end
    end

endmodule

/* design/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  addr_t addr,
    input  word_t write_data,
    input  logic  rd,
    input  logic  wr,
    output word_t read_data,
    output logic  done,
    output logic  stall,
    output logic  cache_hit,
    cache_port_if.controller cache,
    mem_port_if.controller   mem
);

    ctrl_state_t state;
    ctrl_state_t nxt_state;

    logic [$clog2(WORDS_PER_LINE)-1:0] issue_cnt;  // Next word to send to memory
    logic [$clog2(WORDS_PER_LINE)-1:0] recv_cnt;   // Next fill word to arrive

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    offset_t issue_off;
    offset_t recv_off;

    logic    accepted;   // Memory took this cycle's access
    logic    fill_recv;  // Fill word arriving
    logic    hit_q;
    word_t   rdata_q;

    assign req_tag    = addr[15:11];
    assign req_index  = addr[10:3];
    assign req_offset = addr[2:0];
    assign issue_off  = {issue_cnt, 1'b0};
    assign recv_off   = {recv_cnt, 1'b0};

    assign accepted  = (mem.rd || mem.wr) && !mem.busy;
    assign fill_recv = mem.read_valid &&
                       (state == st_fill_issue || state == st_fill_wait);

    // Processor side outputs
    assign done      = (state == st_done);
    assign stall     = (state != st_idle) && (state != st_done);
    assign cache_hit = done && hit_q;
    assign read_data = rdata_q;

    always_comb begin
        nxt_state        = state;

        cache.enable     = 1'b0;
        cache.compare    = 1'b0;
        cache.write      = 1'b0;
        cache.valid_in   = 1'b0;
        cache.index      = req_index;
        cache.tag        = req_tag;
        cache.offset     = req_offset;
        cache.write_data = write_data;

        mem.rd           = 1'b0;
        mem.wr           = 1'b0;
        mem.addr         = {req_tag, req_index, issue_off};  // Fill address
        mem.write_data   = cache.read_data;                  // Victim word

        // Fill words land in the array whenever they arrive
        if (fill_recv) begin
            cache.enable     = 1'b1;
            cache.write      = 1'b1;
            cache.valid_in   = 1'b1;
            cache.offset     = recv_off;
            cache.write_data = mem.read_data;
        end

        case (state)
            st_idle: begin
                if (rd || wr) begin
                    nxt_state = st_compare;
                end
            end

            st_compare: begin
                cache.enable  = 1'b1;
                cache.compare = 1'b1;
                cache.write   = wr;  // Write hit lands this cycle
                if (cache.hit) begin
                    nxt_state = st_done;
                end else if (cache.valid && cache.dirty) begin
                    nxt_state = st_writeback_issue;
                end else begin
                    nxt_state = st_fill_issue;
                end
            end

            st_writeback_issue: begin
                cache.enable = 1'b1;
                cache.offset = issue_off;
                mem.wr       = 1'b1;
                mem.addr     = {cache.tag_out, req_index, issue_off};  // Victim line
                if (accepted && issue_cnt == WORDS_PER_LINE - 1) begin
                    nxt_state = st_writeback_wait;
                end
            end

            // Let the victim writes drain before the refill
            st_writeback_wait: begin
                if (!mem.stall) begin
                    nxt_state = st_fill_issue;
                end
            end

            st_fill_issue: begin
                mem.rd = 1'b1;
                if (accepted && issue_cnt == WORDS_PER_LINE - 1) begin
                    nxt_state = st_fill_wait;
                end
            end

            st_fill_wait: begin
                if (fill_recv && recv_cnt == WORDS_PER_LINE - 1) begin
                    nxt_state = st_fill_finish;
                end
            end

            st_fill_finish: begin
                cache.enable  = 1'b1;
                cache.compare = 1'b1;
                cache.write   = wr;  // Pending write on the new line
                nxt_state     = st_done;
            end

            st_done: begin
                nxt_state = st_idle;
            end

            default: begin
                nxt_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            issue_cnt <= '0;
            recv_cnt  <= '0;
            hit_q     <= 1'b0;
        end else begin
            state <= nxt_state;
            if (accepted) begin
                issue_cnt <= issue_cnt + 1'b1;  // Wraps to 0 after the last word
            end
            if (fill_recv) begin
                recv_cnt <= recv_cnt + 1'b1;
            end
            if (state == st_compare) begin
                hit_q <= cache.hit;
            end
        end
    end

    // Word returned to the processor
    always_ff @(posedge clk) begin
        if (state == st_compare || state == st_fill_finish) begin
            rdata_q <= cache.read_data;
        end
    end

endmodule

/* design/cache_pkg.sv */
package cache_pkg;

    // Processor side address and data
    typedef logic [15:0] addr_t;
    typedef logic [15:0] word_t;

    // Address fields, tag 15:11, index 10:3, offset 2:0
    typedef logic [4:0] tag_t;
    typedef logic [7:0] index_t;
    typedef logic [2:0] offset_t;

    // Bank select, address bits 2:1
    typedef logic [1:0] bank_t;

    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_LINES = 256;
    localparam int MEM_LATENCY = 2;     // Accept to read_valid
    localparam int BANK_OCCUPANCY = 4;  // Busy cycles after accept

    // Cache controller states
    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_done,
        st_writeback_issue,
        st_writeback_wait,
        st_fill_issue,
        st_fill_wait,
        st_fill_finish
    } ctrl_state_t;

endpackage

/* design/cache_port_if.sv */
`timescale 1ns/1ps

interface cache_port_if import cache_pkg::*; ();

    // Request from the controller
    logic    enable;
    logic    compare;     // Tag compare, write only on hit
    logic    write;
    logic    valid_in;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    word_t   write_data;

    // Answer from the array, same cycle
    logic    hit;
    logic    dirty;
    logic    valid;
    tag_t    tag_out;
    word_t   read_data;

    modport controller (
        output enable, compare, write, valid_in, index, tag, offset, write_data,
        input  hit, dirty, valid, tag_out, read_data
    );

    modport array (
        input  enable, compare, write, valid_in, index, tag, offset, write_data,
        output hit, dirty, valid, tag_out, read_data
    );

endinterface

/* design/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if import cache_pkg::*; ();

    addr_t addr;
    word_t write_data;
    logic  rd;
    logic  wr;

    word_t read_data;
    logic  read_valid;  // MEM_LATENCY after an accepted read
    logic  busy;        // Addressed bank occupied
    logic  stall;       // Any bank occupied

    modport controller (
        output addr, write_data, rd, wr,
        input  read_data, read_valid, busy, stall
    );

    modport memory (
        input  addr, write_data, rd, wr,
        output read_data, read_valid, busy, stall
    );

endinterface

/* design/mem_system.sv */
`timescale 1ns/1ps

module mem_system import cache_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  addr_t addr,
    input  word_t write_data,
    input  logic  rd,
    input  logic  wr,
    output word_t read_data,
    output logic  done,
    output logic  stall,
    output logic  cache_hit
);

    cache_port_if cache_bus ();  // Controller to tag/data array
    mem_port_if   mem_bus ();    // Controller to banked memory

    cache_ctrl ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .addr       (addr),
        .write_data (write_data),
        .rd         (rd),
        .wr         (wr),
        .read_data  (read_data),
        .done       (done),
        .stall      (stall),
        .cache_hit  (cache_hit),
        .cache      (cache_bus.controller),
        .mem        (mem_bus.controller)
    );

    cache_array array_i (
        .clk   (clk),
        .reset (reset),
        .cache (cache_bus.array)
    );

    banked_memory memory_i (
        .clk   (clk),
        .reset (reset),
        .mem   (mem_bus.memory)
    );

endmodule

/* filelist.f */
design/cache_pkg.sv
design/cache_port_if.sv
design/mem_port_if.sv
design/cache_ctrl.sv
design/cache_array.sv
design/banked_memory.sv
design/mem_system.sv
bench/mem_system_tb.sv
